//--- aio_port_top.f
src/aio_pkg.sv
src/aio_ctrl.sv
src/gpio_channel.sv
src/aio_pad_mux.sv
src/aio_port_top.sv
dv/aio_port_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the aio_port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/100ps \
	--top-module aio_port_tb \
	-f aio_port_top.f \
	-o aio_port_sim

sim_out=$(./obj_dir/aio_port_sim)
echo "$sim_out"

# The run passes only if the testbench printed its pass line
if echo "$sim_out" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1

//--- dv/aio_port_tb.sv
module aio_port_tb
	import aio_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int data_width = 8;
	localparam int clk_period = 40;
	localparam int num_random = 200;
	localparam int num_directed = 60;
	// Every transaction with its input settle fits in 20 cycles
	localparam int watchdog_cycles = (num_random + num_directed) * 20 + 200;
	localparam int ack_limit = 10;

	logic clk;
	logic rst;
	logic req;
	aio_op_e op;
	logic [chan_w-1:0] chan;
	logic [data_width-1:0] wdata;
	logic ack;
	logic [data_width-1:0] rdata;
	logic tick;
	logic [num_pads-1:0] pad_oe;
	logic [num_pads-1:0] pad_out;
	logic [num_pads-1:0] pad_in;
	logic spi_mosi;
	logic spi_miso;
	logic uart_tx;
	logic uart_rx;
	logic i2c_scl_drive_low;
	logic i2c_sda_drive_low;
	logic i2c_scl_in;
	logic i2c_sda_in;
	logic [num_pads-1:0] irq;

	// Expected register state, kept from the host traffic
	aio_type_e m_type;
	logic [1:0] m_oe;
	logic [1:0] m_out;
	logic [1:0] m_level;
	logic [1:0] m_irq;

	int errors;
	int checks;
	logic [31:0] seed;
	event txn_done;

	aio_port_top #(
		.data_width(data_width)
	) UUT (
		.clk(clk),
		.rst(rst),
		.req(req),
		.op(op),
		.chan(chan),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.tick(tick),
		.pad_oe(pad_oe),
		.pad_out(pad_out),
		.pad_in(pad_in),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx),
		.i2c_scl_drive_low(i2c_scl_drive_low),
		.i2c_sda_drive_low(i2c_sda_drive_low),
		.i2c_scl_in(i2c_scl_in),
		.i2c_sda_in(i2c_sda_in),
		.irq(irq)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// **************************************************
	// Reference pad model
	// **************************************************

	// Result packs {pad_oe, pad_out, gpio_in, miso, rx, scl_in, sda_in}
	function automatic logic [9:0] model_pads(input aio_type_e t, input logic [1:0] oe,
		input logic [1:0] out, input logic mosi, input logic tx, input logic scl_dl,
		input logic sda_dl, input logic [1:0] pin);
		logic [1:0] p_oe;
		logic [1:0] p_out;
		logic [1:0] g_in;
		logic [3:0] eng_in;
		p_oe = 2'b00;
		p_out = 2'b00;
		g_in = 2'b00;
		eng_in = 4'b0000;
		case (t)
			AIO_GPIO:
			begin
				p_oe = oe;
				p_out = out;
				g_in = pin;
			end
			AIO_SPI:
			begin
				p_oe = 2'b01;
				p_out = {1'b0, mosi};
				eng_in[3] = pin[1];
			end
			AIO_UART:
			begin
				p_oe = 2'b01;
				p_out = {1'b0, tx};
				eng_in[2] = pin[1];
			end
			AIO_I2C:
			begin
				// Open drain, only the enable follows the engine
				p_oe = {sda_dl, scl_dl};
				eng_in[1:0] = {pin[0], pin[1]};
			end
			default: ;
		endcase
		return {p_oe, p_out, g_in, eng_in};
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	// Rising edges on the routed GPIO input set the pending flag
	task automatic track_inputs();
		logic [9:0] vec;
		vec = model_pads(m_type, m_oe, m_out, spi_mosi, uart_tx, i2c_scl_drive_low,
			i2c_sda_drive_low, pad_in);
		m_irq = m_irq | (vec[5:4] & ~m_level);
		m_level = vec[5:4];
	endtask

	always @(txn_done)
	begin
		logic [9:0] want;
		want = model_pads(m_type, m_oe, m_out, spi_mosi, uart_tx, i2c_scl_drive_low,
			i2c_sda_drive_low, pad_in);
		check_val("pad_oe", 32'(pad_oe), 32'(want[9:8]));
		check_val("pad_out", 32'(pad_out), 32'(want[7:6]));
		check_val("gpio_in", 32'(UUT.gpio_in), 32'(want[5:4]));
		check_val("engine_in", 32'({spi_miso, uart_rx, i2c_scl_in, i2c_sda_in}), 32'(want[3:0]));
		check_val("irq", 32'(irq), 32'(m_irq));
	end

	// **************************************************
	// Host port driver
	// **************************************************

	task automatic wait_ack(input logic level, output int cycles);
		cycles = 0;
		while (ack !== level && cycles < ack_limit)
		begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (ack !== level)
		begin
			errors++;
			$display("ERROR: ack did not reach %0b within %0d cycles", level, ack_limit);
		end
	endtask

	task automatic xfer_check(input aio_op_e op_i, input logic [chan_w-1:0] chan_i,
		input logic [data_width-1:0] wdata_i, input int hold);
		int cycles;
		logic [data_width-1:0] rd;
		logic [data_width-1:0] want;
		want = '0;
		if (op_i == OP_GET_IN)
			want = data_width'({m_irq[chan_i], m_level[chan_i]});
		check_val("ack_idle", 32'(ack), 32'd0);
		op = op_i;
		chan = chan_i;
		wdata = wdata_i;
		req = 1'b1;
		wait_ack(1'b1, cycles);
		check_val("ack_rise_cycles", 32'(cycles), 32'd3);
		rd = rdata;
		// ack must hold for as long as req does
		repeat (hold)
		begin
			@(posedge clk);
			#2;
			check_val("ack_hold", 32'(ack), 32'd1);
		end
		req = 1'b0;
		wait_ack(1'b0, cycles);
		check_val("ack_fall_cycles", 32'(cycles), 32'd2);
		check_val("rdata", 32'(rd), 32'(want));
		case (op_i)
			OP_SET_TYPE: m_type = aio_type_e'(wdata_i[1:0]);
			OP_SET_DIR: m_oe[chan_i] = wdata_i[0];
			OP_SET_OUT: m_out[chan_i] = wdata_i[0];
			OP_CLR_IRQ: m_irq[chan_i] = 1'b0;
			default: ;
		endcase
		track_inputs();
		->txn_done;
		@(posedge clk);
		#2;
	endtask

	// Apply pad and engine levels, let the synchronizer settle, then compare
	task automatic set_inputs(input logic [1:0] pin, input logic [3:0] eng);
		pad_in = pin;
		{spi_mosi, uart_tx, i2c_scl_drive_low, i2c_sda_drive_low} = eng;
		repeat (3)
		begin
			@(posedge clk);
			#2;
		end
		track_inputs();
		->txn_done;
		@(posedge clk);
		#2;
	endtask

	initial
	begin
		#(watchdog_cycles * clk_period);
		errors++;
		$display("ERROR: watchdog expired before the tests finished");
		$display("Checks: %0d  Errors: %0d", checks, errors);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		errors = 0;
		checks = 0;
		seed = 32'hc414_75fa;
		rst = 1'b1;
		req = 1'b0;
		op = OP_SET_TYPE;
		chan = '0;
		wdata = '0;
		tick = 1'b1;
		pad_in = '0;
		{spi_mosi, uart_tx, i2c_scl_drive_low, i2c_sda_drive_low} = 4'b0000;
		m_type = AIO_GPIO;
		m_oe = 2'b00;
		m_out = 2'b00;
		m_level = 2'b00;
		m_irq = 2'b00;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// Reset state
		check_val("ack", 32'(ack), 32'd0);
		check_val("irq", 32'(irq), 32'd0);
		check_val("pad_oe", 32'(pad_oe), 32'd0);
		xfer_check(OP_GET_IN, 1'b0, '0, 0);
		xfer_check(OP_GET_IN, 1'b1, '0, 0);

		// GPIO outputs per pad
		xfer_check(OP_SET_DIR, 1'b0, data_width'(1), 0);
		xfer_check(OP_SET_OUT, 1'b0, data_width'(1), 1);
		xfer_check(OP_SET_DIR, 1'b1, data_width'(1), 0);
		xfer_check(OP_SET_OUT, 1'b1, data_width'(1), 2);
		xfer_check(OP_SET_OUT, 1'b0, '0, 0);
		xfer_check(OP_SET_DIR, 1'b1, '0, 0);

		// Serial functions on the pads
		for (int t = 1; t < 4; t++)
		begin
			xfer_check(OP_SET_TYPE, 1'b0, data_width'(t), 0);
			repeat (6)
			begin
				seed = xorshift(seed);
				set_inputs(seed[1:0], seed[5:2]);
			end
		end

		// GPIO input, interrupt and clear
		xfer_check(OP_SET_TYPE, 1'b0, '0, 0);
		set_inputs(2'b00, 4'h0);
		xfer_check(OP_CLR_IRQ, 1'b0, '0, 0);
		xfer_check(OP_CLR_IRQ, 1'b1, '0, 0);
		set_inputs(2'b01, 4'h0);
		check_val("irq", 32'(irq), 32'd1);
		xfer_check(OP_GET_IN, 1'b0, '0, 0);
		xfer_check(OP_CLR_IRQ, 1'b0, '0, 0);
		check_val("irq", 32'(irq), 32'd0);
		xfer_check(OP_GET_IN, 1'b0, '0, 0);
		set_inputs(2'b10, 4'h0);
		check_val("irq", 32'(irq), 32'd2);
		xfer_check(OP_GET_IN, 1'b1, '0, 0);
		xfer_check(OP_CLR_IRQ, 1'b1, '0, 0);
		set_inputs(2'b00, 4'h0);
		check_val("irq", 32'(irq), 32'd0);
		xfer_check(OP_GET_IN, 1'b1, '0, 0);

		// Random traffic
		for (int n = 0; n < num_random; n++)
		begin
			seed = xorshift(seed);
			set_inputs(seed[13:12], seed[17:14]);
			xfer_check(aio_op_e'(seed[2:0]), seed[3], seed[11:4], int'(seed[19:18]));
		end

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- src/aio_port_top.sv
module aio_port_top
	import aio_pkg::*;
#(
	parameter int unsigned data_width = 8
)
(
	input  logic clk,
	input  logic rst,

	// Host register port
	input  logic req,
	input  aio_op_e op,
	input  logic [chan_w-1:0] chan,
	input  logic [data_width-1:0] wdata,
	output logic ack,
	output logic [data_width-1:0] rdata,

	input  logic tick,

	// Pads
	output logic [num_pads-1:0] pad_oe,
	output logic [num_pads-1:0] pad_out,
	input  logic [num_pads-1:0] pad_in,

	// Serial engine lines
	input  logic spi_mosi,
	output logic spi_miso,
	input  logic uart_tx,
	output logic uart_rx,
	input  logic i2c_scl_drive_low,
	input  logic i2c_sda_drive_low,
	output logic i2c_scl_in,
	output logic i2c_sda_in,

	output logic [num_pads-1:0] irq
);

	aio_type_e aio_type;
	logic [num_pads-1:0] dir_we;
	logic [num_pads-1:0] out_we;
	logic [num_pads-1:0] irq_clr;
	logic wbit;
	logic [num_pads-1:0][data_width-1:0] status;
	logic [num_pads-1:0] gpio_oe;
	logic [num_pads-1:0] gpio_out;
	logic [num_pads-1:0] gpio_in;

	aio_ctrl #(
		.data_width(data_width)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.req(req),
		.op(op),
		.chan(chan),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.aio_type(aio_type),
		.dir_we(dir_we),
		.out_we(out_we),
		.irq_clr(irq_clr),
		.wbit(wbit),
		.status(status)
	);

	// One GPIO channel per pad
	for (genvar i = 0; i < num_pads; i++)
	begin : g_gpio
		gpio_channel #(
			.data_width(data_width)
		) u_gpio (
			.clk(clk),
			.rst(rst),
			.tick(tick),
			.dir_we(dir_we[i]),
			.out_we(out_we[i]),
			.irq_clr(irq_clr[i]),
			.wbit(wbit),
			.gpio_oe(gpio_oe[i]),
			.gpio_out(gpio_out[i]),
			.gpio_in(gpio_in[i]),
			.status(status[i]),
			.irq(irq[i])
		);
	end

	aio_pad_mux u_pad_mux (
		.aio_type(aio_type),
		.gpio_oe(gpio_oe),
		.gpio_out(gpio_out),
		.gpio_in(gpio_in),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx),
		.i2c_scl_drive_low(i2c_scl_drive_low),
		.i2c_sda_drive_low(i2c_sda_drive_low),
		.i2c_scl_in(i2c_scl_in),
		.i2c_sda_in(i2c_sda_in),
		.pad_oe(pad_oe),
		.pad_out(pad_out),
		.pad_in(pad_in)
	);

endmodule

//--- src/aio_pad_mux.sv
module aio_pad_mux
	import aio_pkg::*;
(
	input  aio_type_e aio_type,

	input  logic [num_pads-1:0] gpio_oe,
	input  logic [num_pads-1:0] gpio_out,
	output logic [num_pads-1:0] gpio_in,

	input  logic spi_mosi,
	output logic spi_miso,
	input  logic uart_tx,
	output logic uart_rx,
	input  logic i2c_scl_drive_low,
	input  logic i2c_sda_drive_low,
	output logic i2c_scl_in,
	output logic i2c_sda_in,

	output logic [num_pads-1:0] pad_oe,
	output logic [num_pads-1:0] pad_out,
	input  logic [num_pads-1:0] pad_in
);

	// Serial pad roles
	localparam int unsigned pad_tx = 0;
	localparam int unsigned pad_rx = 1;
	localparam int unsigned pad_scl = 0;
	localparam int unsigned pad_sda = 1;

	// **************************************************
	// Pad routing per function
	// **************************************************

	always_comb
	begin
		// Undriven pads and unselected consumers sit at 0
		pad_oe = '0;
		pad_out = '0;
		gpio_in = '0;
		spi_miso = 1'b0;
		uart_rx = 1'b0;
		i2c_scl_in = 1'b0;
		i2c_sda_in = 1'b0;

		case (aio_type)
			AIO_GPIO:
			begin
				pad_oe = gpio_oe;
				pad_out = gpio_out;
				gpio_in = pad_in;
			end
			AIO_SPI:
			begin
				pad_oe[pad_tx] = 1'b1;
				pad_out[pad_tx] = spi_mosi;
				spi_miso = pad_in[pad_rx];
			end
			AIO_UART:
			begin
				pad_oe[pad_tx] = 1'b1;
				pad_out[pad_tx] = uart_tx;
				uart_rx = pad_in[pad_rx];
			end
			AIO_I2C:
			begin
				// Open drain, the pad value stays 0 and only oe toggles
				pad_oe[pad_scl] = i2c_scl_drive_low;
				pad_oe[pad_sda] = i2c_sda_drive_low;
				i2c_scl_in = pad_in[pad_scl];
				i2c_sda_in = pad_in[pad_sda];
			end
			default: ;
		endcase
	end

	// Pad owner must resolve to one of the four functions
	a_type_known: assert property (
		@(aio_type) !$isunknown(aio_type)
	);

endmodule

//--- src/gpio_channel.sv
module gpio_channel
#(
	parameter int unsigned data_width = 8
)
(
	input  logic clk,
	input  logic rst,
	input  logic tick,

	input  logic dir_we,
	input  logic out_we,
	input  logic irq_clr,
	input  logic wbit,

	output logic gpio_oe,
	output logic gpio_out,
	input  logic gpio_in,

	output logic [data_width-1:0] status,
	output logic irq
);

	logic oe_q;
	logic out_q;
	logic [1:0] sync_q;
	logic irq_q;
	logic rise_evt;

	// **************************************************
	// Output enable and output value
	// **************************************************

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			oe_q <= 1'b0;
			out_q <= 1'b0;
		end
		else
		begin
			if (dir_we)
				oe_q <= wbit;
			if (out_we)
				out_q <= wbit;
		end
	end

	assign gpio_oe = oe_q;
	assign gpio_out = out_q;

	// **************************************************
	// Input synchronizer and edge interrupt
	// **************************************************

	// Both stages advance only on a tick
	always_ff @(posedge clk)
	begin
		if (rst)
			sync_q <= 2'b00;
		else if (tick)
			sync_q <= {sync_q[0], gpio_in};
	end

	// Rising edge of the synchronized level, seen as it is loaded
	assign rise_evt = tick & sync_q[0] & ~sync_q[1];

	always_ff @(posedge clk)
	begin
		if (rst)
			irq_q <= 1'b0;
		else if (irq_clr)
			irq_q <= 1'b0;   // clear beats a same-cycle edge
		else if (rise_evt)
			irq_q <= 1'b1;
	end

	assign irq = irq_q;

	// Status word: bit 0 input level, bit 1 pending interrupt
	always_comb
	begin
		status = '0;
		status[0] = sync_q[1];
		status[1] = irq_q;
	end

	// After a clear, irq returns only on a fresh rising edge
	a_irq_after_clear: assert property (
		@(posedge clk) disable iff (rst)
		irq_clr |=> !irq ##1 (!irq || $past(rise_evt))
	);

endmodule

//--- src/aio_ctrl.sv
module aio_ctrl
	import aio_pkg::*;
#(
	parameter int unsigned data_width = 8
)
(
	input  logic clk,
	input  logic rst,

	input  logic req,
	input  aio_op_e op,
	input  logic [chan_w-1:0] chan,
	input  logic [data_width-1:0] wdata,
	output logic ack,
	output logic [data_width-1:0] rdata,

	output aio_type_e aio_type,

	output logic [num_pads-1:0] dir_we,
	output logic [num_pads-1:0] out_we,
	output logic [num_pads-1:0] irq_clr,
	output logic wbit,
	input  logic [num_pads-1:0][data_width-1:0] status
);

	ctrl_state_e state;

	// **************************************************
	// Four-phase handshake FSM
	// **************************************************

	// IDLE -> EXEC -> ACK -> WAIT_DROP -> IDLE
	// ack is registered, so it rises two edges after req is seen
	// and drops one edge after req is seen low
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= CS_IDLE;
			ack <= 1'b0;
			aio_type <= AIO_GPIO;
		end
		else
		begin
			case (state)
				CS_IDLE:
				begin
					ack <= 1'b0;
					if (req)
						state <= CS_EXEC;
				end
				CS_EXEC:
				begin
					if (op == OP_SET_TYPE)
						aio_type <= aio_type_e'(wdata[aio_type_w-1:0]);
					state <= CS_ACK;
				end
				CS_ACK:
				begin
					ack <= 1'b1;
					state <= CS_WAIT_DROP;
				end
				CS_WAIT_DROP:
				begin
					// Host holds req as long as it needs rdata
					if (!req)
						state <= CS_IDLE;
				end
				default:
				begin
					state <= CS_IDLE;
				end
			endcase
		end
	end

	// Read data, zero for every operation except a status read
	always_ff @(posedge clk)
	begin
		if (state == CS_EXEC)
		begin
			if (op == OP_GET_IN)
				rdata <= status[chan];
			else
				rdata <= '0;
		end
	end

	// **************************************************
	// Channel strobes
	// **************************************************

	// One-cycle pulse to the addressed channel while in EXEC
	always_comb
	begin
		dir_we = '0;
		out_we = '0;
		irq_clr = '0;
		if (state == CS_EXEC)
		begin
			case (op)
				OP_SET_DIR: dir_we[chan] = 1'b1;
				OP_SET_OUT: out_we[chan] = 1'b1;
				OP_CLR_IRQ: irq_clr[chan] = 1'b1;
				default: ;
			endcase
		end
	end

	// Shared write bit for direction and output updates
	assign wbit = wdata[0];

	// ack must only answer a pending request
	// The edge that raised ack is the one before its rise is seen
	a_ack_needs_req: assert property (
		@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req)
	);

	// Never more than one channel register touched per cycle
	a_single_strobe: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0({dir_we, out_we, irq_clr})
	);

endmodule

//--- src/aio_pkg.sv
package aio_pkg;

	// **************************************************
	// Widths shared across the port block
	// **************************************************

	// Pad count equals GPIO channel count; the pad wiring is per pad
	localparam int unsigned num_pads = 2;

	// Channel select width on the host port
	localparam int unsigned chan_w = $clog2(num_pads);

	localparam int unsigned aio_type_w = 2;
	localparam int unsigned aio_op_w = 3;
	localparam int unsigned ctrl_state_w = 2;

	// **************************************************
	// Enumerations
	// **************************************************

	// Owner of the two pads
	typedef enum logic [aio_type_w-1:0] {
		AIO_GPIO = 2'd0,
		AIO_SPI  = 2'd1,
		AIO_UART = 2'd2,
		AIO_I2C  = 2'd3
	} aio_type_e;

	// Host operations, codes 5 to 7 are accepted as no-ops
	typedef enum logic [aio_op_w-1:0] {
		OP_SET_TYPE = 3'd0,
		OP_SET_DIR  = 3'd1,
		OP_SET_OUT  = 3'd2,
		OP_GET_IN   = 3'd3,
		OP_CLR_IRQ  = 3'd4
	} aio_op_e;

	// Handshake FSM of the control block
	typedef enum logic [ctrl_state_w-1:0] {
		CS_IDLE      = 2'd0,
		CS_EXEC      = 2'd1,
		CS_ACK       = 2'd2,
		CS_WAIT_DROP = 2'd3
	} ctrl_state_e;

endpackage
